// File: common/cgra_defs.svh
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// array size
`define CGRA_N_STAGE 4
`define CGRA_STAGE_W 2

// bus and word widths
`define CGRA_DATA_W 16
`define CGRA_ADDR_W 32

// 64 words of local memory per stage
`define CGRA_MEM_AW 6

// configuration register index
`define CGRA_CONF_AW 3
`define CGRA_GLOBAL_CLEAR 3'd7

// host address fields, low to high: offset, stage, region
`define CGRA_STAGE_LSB `CGRA_MEM_AW
`define CGRA_REGION_LSB (`CGRA_MEM_AW + `CGRA_STAGE_W)

`endif

// File: common/cgra_pkg.sv
`default_nettype none

`include "cgra_defs.svh"

package cgra_pkg;

   // top two address bits of a host access
   typedef enum logic [1:0] {
      region_mem  = 2'd0,
      region_run  = 2'd1,
      region_conf = 2'd2
   } region_e;

   typedef enum logic [`CGRA_CONF_AW-1:0] {
      conf_src   = 3'd0,
      conf_dst   = 3'd1,
      conf_len   = 3'd2,
      conf_op    = 3'd3,
      conf_bsel  = 3'd4,
      conf_const = 3'd5
   } conf_reg_e;

   // results truncated to the data width
   typedef enum logic [2:0] {
      op_add    = 3'd0,
      op_sub    = 3'd1,
      op_and    = 3'd2,
      op_or     = 3'd3,
      op_xor    = 3'd4,
      op_pass_a = 3'd5
   } alu_op_e;

   typedef enum logic [1:0] {
      st_idle   = 2'd0,
      st_stream = 2'd1,
      st_drain  = 2'd2,
      st_done   = 2'd3
   } run_state_e;

   // bsel 0 takes the constant, 1 takes the incoming flow
   typedef struct packed {
      logic [6:0]              spare;
      logic [`CGRA_MEM_AW-1:0] src_base;
      logic [`CGRA_MEM_AW-1:0] dst_base;
      logic [`CGRA_MEM_AW:0]   len;
      alu_op_e                 op;
      logic                    bsel;
      logic [`CGRA_DATA_W-1:0] cval;
   } stage_conf_t;

   // word passed to the next stage of the ring
   typedef struct packed {
      logic                    valid;
      logic [`CGRA_MEM_AW-1:0] index;
      logic [`CGRA_DATA_W-1:0] data;
   } flow_t;

endpackage

`default_nettype wire

// File: stage/stage_conf.sv
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module stage_conf (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        wr_en,
   input  wire                        rd_sel,
   input  wire cgra_pkg::conf_reg_e   index,
   input  wire                        global_clear,
   input  wire [`CGRA_DATA_W-1:0]     rdata,
   output logic [`CGRA_DATA_W-1:0]    rd_word,
   output cgra_pkg::stage_conf_t      conf
);

   // spare bits are never written, so they stay at zero
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         conf <= '0;
      end else if (global_clear) begin
         conf <= '0;
      end else if (wr_en) begin
         case (index)
            cgra_pkg::conf_src:   conf.src_base <= rdata[`CGRA_MEM_AW-1:0];
            cgra_pkg::conf_dst:   conf.dst_base <= rdata[`CGRA_MEM_AW-1:0];
            cgra_pkg::conf_len:   conf.len      <= rdata[`CGRA_MEM_AW:0];
            cgra_pkg::conf_op:    conf.op       <= cgra_pkg::alu_op_e'(rdata[2:0]);
            cgra_pkg::conf_bsel:  conf.bsel     <= rdata[0];
            cgra_pkg::conf_const: conf.cval     <= rdata;
            default: ;
         endcase
      end
   end

   // readback, zero-extended
   always_comb begin
      rd_word = '0;
      if (rd_sel) begin
         case (index)
            cgra_pkg::conf_src:   rd_word[`CGRA_MEM_AW-1:0] = conf.src_base;
            cgra_pkg::conf_dst:   rd_word[`CGRA_MEM_AW-1:0] = conf.dst_base;
            cgra_pkg::conf_len:   rd_word[`CGRA_MEM_AW:0]   = conf.len;
            cgra_pkg::conf_op:    rd_word[2:0]              = conf.op;
            cgra_pkg::conf_bsel:  rd_word[0]                = conf.bsel;
            cgra_pkg::conf_const: rd_word                   = conf.cval;
            default: ;
         endcase
      end
   end

   // the top decodes the clear code, the stage gates the write
   a_no_wr_on_clear: assert property (@(posedge clk) disable iff (rst)
      wr_en |-> !global_clear);

endmodule

`default_nettype wire

// File: stage/stage_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module stage_datapath (
   input  wire                        clk,
   input  wire                        rst,
   input  wire cgra_pkg::stage_conf_t conf,
   input  wire                        start,
   input  wire                        host_we,
   input  wire                        host_re,
   input  wire [`CGRA_MEM_AW-1:0]     host_addr,
   input  wire [`CGRA_DATA_W-1:0]     rdata,
   input  wire cgra_pkg::flow_t       flow_in,
   output logic [`CGRA_DATA_W-1:0]    host_rd,
   output logic                       done,
   output cgra_pkg::flow_t            flow_out
);

   logic [`CGRA_DATA_W-1:0] mem [0:(1 << `CGRA_MEM_AW)-1];
   cgra_pkg::run_state_e    state;
   logic [`CGRA_MEM_AW:0]   cnt;
   logic                    run_rd;
   logic [`CGRA_MEM_AW-1:0] rd_idx;
   logic [`CGRA_MEM_AW-1:0] rd_addr;
   logic [`CGRA_MEM_AW-1:0] rd_idx_q;
   logic [`CGRA_MEM_AW-1:0] res_idx_q;
   logic                    rd_valid_q;
   logic                    res_valid_q;
   logic [`CGRA_DATA_W-1:0] mem_q;
   logic [`CGRA_DATA_W-1:0] op_b;
   logic [`CGRA_DATA_W-1:0] alu_res;
   logic [`CGRA_DATA_W-1:0] res_q;

   // word 0 is read in the start cycle itself
   always_comb begin
      run_rd  = start ? (conf.len != '0) : (state == cgra_pkg::st_stream);
      rd_idx  = start ? '0 : cnt[`CGRA_MEM_AW-1:0];
      rd_addr = run_rd ? conf.src_base + rd_idx : host_addr;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= cgra_pkg::st_idle;
         cnt   <= '0;
      end else if (start) begin
         cnt   <= {{`CGRA_MEM_AW{1'b0}}, 1'b1};
         state <= (conf.len[`CGRA_MEM_AW:1] != '0) ? cgra_pkg::st_stream
                                                    : cgra_pkg::st_drain;
      end else begin
         case (state)
            cgra_pkg::st_stream: begin
               cnt <= cnt + 1'b1;
               if (cnt == conf.len - 1'b1)
                  state <= cgra_pkg::st_drain;
            end
            // last write leaves the pipe one cycle after the last read data
            cgra_pkg::st_drain: if (!rd_valid_q) state <= cgra_pkg::st_done;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_valid_q  <= 1'b0;
         res_valid_q <= 1'b0;
      end else begin
         rd_valid_q  <= run_rd;
         res_valid_q <= rd_valid_q;
      end
   end

   always_ff @(posedge clk) begin
      rd_idx_q  <= rd_idx;
      res_idx_q <= rd_idx_q;
      res_q     <= alu_res;
   end

   // one read port, one write port; the run write wins
   always_ff @(posedge clk) begin
      if (res_valid_q)
         mem[conf.dst_base + res_idx_q] <= res_q;
      else if (host_we)
         mem[host_addr] <= rdata;
      if (run_rd || host_re)
         mem_q <= mem[rd_addr];
   end

   always_comb begin
      flow_out.valid = rd_valid_q;
      flow_out.index = rd_idx_q;
      flow_out.data  = mem_q;
   end

   always_comb begin
      op_b = conf.bsel ? flow_in.data : conf.cval;
      case (conf.op)
         cgra_pkg::op_add:    alu_res = mem_q + op_b;
         cgra_pkg::op_sub:    alu_res = mem_q - op_b;
         cgra_pkg::op_and:    alu_res = mem_q & op_b;
         cgra_pkg::op_or:     alu_res = mem_q | op_b;
         cgra_pkg::op_xor:    alu_res = mem_q ^ op_b;
         default:             alu_res = mem_q;
      endcase
   end

   assign host_rd = mem_q;
   assign done    = (state == cgra_pkg::st_done);

   a_no_host_wr_in_run: assert property (@(posedge clk) disable iff (rst)
      host_we |-> !(state inside {cgra_pkg::st_stream, cgra_pkg::st_drain}));

   // previous stage must deliver the same word index in lockstep
   a_flow_aligned: assert property (@(posedge clk) disable iff (rst)
      (conf.bsel && rd_valid_q) |-> (flow_in.valid && flow_in.index == rd_idx_q));

endmodule

`default_nettype wire

// File: stage/stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module stage (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     valid,
   input  wire                     we,
   input  wire                     conf_sel,
   input  wire                     global_clear,
   input  wire                     run,
   input  wire [`CGRA_MEM_AW-1:0]  offset,
   input  wire [`CGRA_DATA_W-1:0]  rdata,
   input  wire cgra_pkg::flow_t    flow_in,
   output logic [`CGRA_DATA_W-1:0] wdata,
   output logic                    done,
   output cgra_pkg::flow_t         flow_out
);

   cgra_pkg::stage_conf_t   conf;
   logic                    valid_q;
   logic                    start;
   logic                    conf_wr;
   logic                    mem_we;
   logic                    mem_re;
   logic [`CGRA_DATA_W-1:0] conf_rd;
   logic [`CGRA_DATA_W-1:0] mem_rd;
   logic [`CGRA_DATA_W-1:0] mem_rd_q;

   // a held valid must not restart the run
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         valid_q <= 1'b0;
      else
         valid_q <= valid;
   end

   assign start   = run & we & valid & ~valid_q;
   assign conf_wr = valid & we & conf_sel &
                    (offset[`CGRA_CONF_AW-1:0] != `CGRA_GLOBAL_CLEAR);
   assign mem_we  = valid & we & ~conf_sel & ~run;
   assign mem_re  = valid & ~we & ~conf_sel & ~run;

   stage_conf u_conf (
      .clk          (clk),
      .rst          (rst),
      .wr_en        (conf_wr),
      .rd_sel       (conf_sel),
      .index        (cgra_pkg::conf_reg_e'(offset[`CGRA_CONF_AW-1:0])),
      .global_clear (global_clear),
      .rdata        (rdata),
      .rd_word      (conf_rd),
      .conf         (conf)
   );

   stage_datapath u_datapath (
      .clk       (clk),
      .rst       (rst),
      .conf      (conf),
      .start     (start),
      .host_we   (mem_we),
      .host_re   (mem_re),
      .host_addr (offset),
      .rdata     (rdata),
      .flow_in   (flow_in),
      .host_rd   (mem_rd),
      .done      (done),
      .flow_out  (flow_out)
   );

   // second register stage lines memory data up with the 3-cycle ready
   always_ff @(posedge clk) begin
      mem_rd_q <= mem_rd;
   end

   assign wdata = conf_sel ? conf_rd : mem_rd_q;

endmodule

`default_nettype wire

// File: verilog/cgra_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_top (
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     valid,
   input  wire [`CGRA_ADDR_W-1:0]  addr,
   input  wire                     we,
   input  wire [`CGRA_DATA_W-1:0]  rdata,
   output logic                    ready,
   output logic [`CGRA_DATA_W-1:0] wdata
);

   cgra_pkg::region_e        region;
   logic [`CGRA_STAGE_W-1:0] stage_sel;
   logic [`CGRA_MEM_AW-1:0]  offset;
   logic                     is_mem;
   logic                     is_run;
   logic                     is_conf;
   logic                     clear_code;
   logic                     broadcast;
   logic                     global_clear;
   logic [`CGRA_N_STAGE-1:0] stage_valid;
   logic [`CGRA_N_STAGE-1:0] stage_done;
   logic [`CGRA_DATA_W-1:0]  stage_wdata [`CGRA_N_STAGE];
   logic                     ready_d1;
   logic                     ready_d2;

   // one extra entry so the last stage wraps back to the first
   cgra_pkg::flow_t          flow_bus [`CGRA_N_STAGE+1];

   assign region     = cgra_pkg::region_e'(addr[`CGRA_REGION_LSB +: 2]);
   assign stage_sel  = addr[`CGRA_STAGE_LSB +: `CGRA_STAGE_W];
   assign offset     = addr[`CGRA_MEM_AW-1:0];
   assign is_mem     = (region == cgra_pkg::region_mem);
   assign is_run     = (region == cgra_pkg::region_run);
   assign is_conf    = (region == cgra_pkg::region_conf);
   assign clear_code = is_conf & (offset[`CGRA_CONF_AW-1:0] == `CGRA_GLOBAL_CLEAR);
   assign broadcast  = is_run | clear_code;
   assign global_clear = valid & we & clear_code;

   always_comb begin
      for (int j = 0; j < `CGRA_N_STAGE; j++) begin
         stage_valid[j] = valid & (broadcast | (stage_sel == j[`CGRA_STAGE_W-1:0]));
      end
   end

   // memory reads wait for the two read registers, all else answers next cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_d1 <= 1'b0;
         ready_d2 <= 1'b0;
         ready    <= 1'b0;
      end else begin
         ready_d1 <= valid;
         ready_d2 <= ready_d1 & valid;
         if (is_mem && !we)
            ready <= ready_d2 & valid;
         else
            ready <= valid;
      end
   end

   always_comb begin
      if (is_run)
         wdata = {{(`CGRA_DATA_W-1){1'b0}}, &stage_done};
      else
         wdata = stage_wdata[stage_sel];
   end

   genvar i;
   generate
      for (i = 0; i < `CGRA_N_STAGE; i++) begin : stage_array
         stage u_stage (
            .clk          (clk),
            .rst          (rst),
            .valid        (stage_valid[i]),
            .we           (we),
            .conf_sel     (is_conf),
            .global_clear (global_clear),
            .run          (is_run),
            .offset       (offset),
            .rdata        (rdata),
            .flow_in      (flow_bus[i]),
            .wdata        (stage_wdata[i]),
            .done         (stage_done[i]),
            .flow_out     (flow_bus[i+1])
         );
      end
   endgenerate

   // ring closure, stage 0 listens to the last stage
   assign flow_bus[0] = flow_bus[`CGRA_N_STAGE];

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   output logic clk
);

   localparam int period_ns = 100;

   initial begin
      clk = 1'b0;
      forever #(period_ns / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

// File: verif/cgra_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_tb;

   localparam int drive_delay = 5;
   localparam int ready_limit = 20;
   localparam logic [`CGRA_ADDR_W-1:0] run_addr =
      `CGRA_ADDR_W'(cgra_pkg::region_run) << `CGRA_REGION_LSB;

   wire                      clk;
   logic                     rst;
   logic                     valid;
   logic [`CGRA_ADDR_W-1:0]  addr;
   logic                     we;
   logic [`CGRA_DATA_W-1:0]  rdata;
   wire                      ready;
   wire [`CGRA_DATA_W-1:0]   wdata;

   int                       errors;
   int                       timeouts;
   int                       cycle_cnt;
   logic [31:0]              lfsr_state;

   tb_clock u_clock (
      .clk (clk)
   );

   cgra_top dut (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .rdata (rdata),
      .ready (ready),
      .wdata (wdata)
   );

   // galois form, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // inputs change a little after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #drive_delay;
      cycle_cnt++;
   endtask

   task automatic idle_gap();
      logic [1:0] n;
      n[0] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      n[1] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      repeat (n) next_cycle();
   endtask

   // one bus access, held until ready, then valid low for a cycle
   task automatic bus_access(input logic [`CGRA_ADDR_W-1:0] a, input logic w,
                             input logic [`CGRA_DATA_W-1:0] d,
                             output logic [`CGRA_DATA_W-1:0] rd, output logic ok);
      int lat;
      int exp_lat;
      // memory reads pass two read registers, everything else answers next cycle
      exp_lat = (a[`CGRA_REGION_LSB +: 2] == cgra_pkg::region_mem && !w) ? 3 : 1;
      valid = 1'b1;
      addr = a;
      we = w;
      rdata = d;
      lat = 0;
      ok = 1'b0;
      while (!ok && lat < ready_limit) begin
         next_cycle();
         lat++;
         ok = ready;
      end
      rd = wdata;
      valid = 1'b0;
      we = 1'b0;
      if (!ok) begin
         $display("ready never came within %0d cycles for address %h", ready_limit, a);
         timeouts++;
      end else if (lat != exp_lat) begin
         $display("Fail ready latency at addr %h: expected %h, got %h", a, exp_lat, lat);
         errors++;
      end
      next_cycle();
   endtask

   // reads the done word until bit 0 is set
   task automatic poll_done(input int limit);
      logic [`CGRA_DATA_W-1:0] rd;
      logic                    ok;
      logic                    seen;
      int                      start;
      start = cycle_cnt;
      seen = 1'b0;
      while (!seen && cycle_cnt - start <= limit) begin
         bus_access(run_addr, 1'b0, '0, rd, ok);
         seen = ok && rd[0];
      end
      if (!seen) begin
         $display("done did not rise within %0d cycles", limit);
         timeouts++;
      end
   endtask

   initial begin
      logic [7:0]              cmd;
      logic [1023:0]           skip_line;
      logic [`CGRA_ADDR_W-1:0] a;
      logic [`CGRA_DATA_W-1:0] d;
      logic [`CGRA_DATA_W-1:0] rd;
      logic                    ok;
      int                      fd;
      int                      n;
      int                      limit;
      rst = 1'b1;
      valid = 1'b0;
      addr = '0;
      we = 1'b0;
      rdata = '0;
      errors = 0;
      timeouts = 0;
      cycle_cnt = 0;
      lfsr_state = 32'ha9fd_f24b;
      repeat (16) next_cycle();
      rst = 1'b0;
      next_cycle();
      if (ready !== 1'b0) begin
         $display("Fail ready after reset: expected %h, got %h", 1'b0, ready);
         errors++;
      end

      fd = $fopen("verif/cgra_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open the test file verif/cgra_tests.txt");
         errors++;
      end else begin
         while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
               n = $fgets(skip_line, fd);
            end else if (cmd == "W") begin
               n = $fscanf(fd, "%h %h", a, d);
               if (n != 2) begin
                  $display("could not read the address and data of a write command");
                  errors++;
               end else begin
                  bus_access(a, 1'b1, d, rd, ok);
               end
               idle_gap();
            end else if (cmd == "R") begin
               n = $fscanf(fd, "%h %h", a, d);
               if (n != 2) begin
                  $display("could not read the address and expected value of a read command");
                  errors++;
               end else begin
                  bus_access(a, 1'b0, '0, rd, ok);
                  if (ok && rd !== d) begin
                     $display("Fail wdata at addr %h: expected %h, got %h", a, d, rd);
                     errors++;
                  end
               end
               idle_gap();
            end else if (cmd == "P") begin
               n = $fscanf(fd, "%d", limit);
               if (n != 1) begin
                  $display("could not read the cycle limit of a poll command");
                  errors++;
               end else begin
                  poll_done(limit);
               end
               idle_gap();
            end else begin
               $display("unknown command '%c' in the test file", cmd);
               errors++;
            end
         end
         $fclose(fd);
      end

      $display("closing: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/cgra_pkg.sv
stage/stage_conf.sv
stage/stage_datapath.sv
stage/stage.sv
verilog/cgra_top.sv
verif/tb_clock.sv
verif/cgra_tb.sv

// File: Makefile
# Verilator build for the CGRA testbench

VERILATOR  ?= verilator
TOP        := cgra_tb
FILELIST   := all.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_BIN    := obj_dir/V$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verif/cgra_tests.txt
# W addr data = host write, R addr expected = host read and compare (hex)
# P limit = read the done word until bit 0 is set, within limit cycles (decimal)
R 100 0000
# two source words per stage
W 000 1234
W 001 8001
W 040 0f0f
W 041 0100
W 080 a5a5
W 081 00ff
W 0c0 3c3c
W 0c1 ffff
R 000 1234
R 041 0100
R 080 a5a5
R 0c1 ffff
# constant operand run: add, sub, xor, and
W 201 ffd0
W 202 0002
W 205 1111
W 241 0010
W 242 0002
W 243 fff9
W 245 0010
W 281 0010
W 282 ff82
W 283 0004
W 285 ff00
W 2c1 0010
W 2c2 0002
W 2c3 0002
W 2c5 0ff0
R 201 0010
R 243 0001
R 282 0002
R 205 1111
R 245 0010
R 2c5 0ff0
R 200 0000
W 100 0001
P 40
R 010 2345
R 011 9112
R 050 0eff
R 051 00f0
R 090 5aa5
R 091 ffff
R 0d0 0c30
R 0d1 0ff0
# ring flow, stage 0 takes stage 3
W 204 ffff
W 244 0001
W 284 0001
W 2c4 0001
W 201 0020
W 241 0020
W 281 0020
W 2c1 0020
R 204 0001
W 100 0001
P 40
R 020 4e70
R 021 8000
R 060 fcdb
R 061 80ff
R 0a0 aaaa
R 0a1 01ff
R 0e0 2424
R 0e1 00ff
# long run on stage 2, done low right after start
W 282 0028
W 284 0000
W 100 0001
R 100 0000
P 200
# global clear, then an empty run
W 207 0000
R 202 0000
R 244 0000
R 285 0000
R 2c1 0000
W 100 0001
P 20
R 000 1234
R 050 0eff
R 060 fcdb
R 0e0 2424
